// ==== build.f ====
+incdir+source
source/mpmc_pkg.sv
source/chan_port.sv
source/mem_sequencer.sv
source/mpmc_top.sv
dv/mem_model.sv
dv/mpmc_tb.sv

// ==== dv/mem_model.sv ====
`include "mpmc_params.svh"

module mem_model #(
	parameter logic [31:0] SEED = 32'd67556,
	parameter int LAT = 3
) (
	input  logic mem_ui_clk,
	input  logic mem_ui_rst,
	input  logic [28:0] mem_addr,
	input  logic [2:0] mem_cmd,
	input  logic mem_en,
	input  logic [127:0] mem_wdf_data,
	input  logic [15:0] mem_wdf_mask,
	input  logic mem_wdf_wren,
	input  logic mem_wdf_end,
	output logic mem_rdy,
	output logic mem_wdf_rdy,
	output logic [127:0] mem_rd_data,
	output logic mem_rd_data_valid
);

	logic [127:0] store [4096];
	logic [127:0] wbuf;
	logic [15:0] wmsk;
	logic [LAT-1:0] pv;
	logic [127:0] pd [LAT];
	logic [31:0] lcg;

	// Every 32-bit word of the fill depends on its full word address
	initial begin
		mem_rdy <= 1'b0;
		mem_wdf_rdy <= 1'b0;
		mem_rd_data <= '0;
		mem_rd_data_valid <= 1'b0;
		for (int i = 0; i < 4096; i++) begin
			for (int j = 0; j < 4; j++) begin
				store[i][j*32 +: 32] = (32'(i * 4 + j) * 32'h9E3779B1) ^ 32'h5A5A0000;
			end
		end
	end

	always @(posedge mem_ui_clk) begin
		if (mem_ui_rst) begin
			lcg = SEED;
			mem_rdy <= 1'b0;
			mem_wdf_rdy <= 1'b0;
			pv <= '0;
			mem_rd_data_valid <= 1'b0;
			mem_rd_data <= '0;
		end else begin
			// Random stalls on both ready lines about one cycle in four
			lcg = lcg * 32'd1103515245 + 32'd12345;
			mem_rdy <= (lcg[31:30] != 2'd0);
			mem_wdf_rdy <= (lcg[29:28] != 2'd0);
			// Single strip writes, so every data beat is the last
			if (mem_wdf_wren && mem_wdf_rdy && mem_wdf_end) begin
				wbuf <= mem_wdf_data;
				wmsk <= mem_wdf_mask;
			end
			if (mem_en && mem_rdy && mem_cmd == `MPMC_CMD_WR) begin
				for (int b = 0; b < 16; b++) begin
					if (!wmsk[b]) begin
						store[mem_addr[15:4]][b*8 +: 8] <= wbuf[b*8 +: 8];
					end
				end
			end
			// Fixed latency read pipe
			pv <= {pv[LAT-2:0], mem_en && mem_rdy && mem_cmd == `MPMC_CMD_RD};
			pd[0] <= store[mem_addr[15:4]];
			for (int i = LAT - 1; i > 0; i--) begin
				pd[i] <= pd[i-1];
			end
			mem_rd_data <= pd[LAT-1];
			mem_rd_data_valid <= pv[LAT-1];
		end
	end

endmodule

// ==== dv/mpmc_tb.sv ====
`include "mpmc_params.svh"

module mpmc_tb;

	localparam int NTESTS = 6;

	logic mem_ui_clk;
	logic mem_ui_rst;
	logic cyc0, stb0, we0, ack0;
	logic [15:0] sel0;
	logic [31:0] adr0;
	logic [127:0] dat_w0, dat_r0;
	logic cyc1, stb1, we1, ack1;
	logic [7:0] sel1;
	logic [31:0] adr1;
	logic [63:0] dat_w1, dat_r1;
	logic cyc2, stb2, we2, ack2;
	logic [3:0] sel2;
	logic [31:0] adr2;
	logic [31:0] dat_w2, dat_r2;
	logic [28:0] mem_addr;
	logic [2:0] mem_cmd;
	logic mem_en, mem_wdf_wren, mem_wdf_end, mem_rdy, mem_wdf_rdy, mem_rd_data_valid;
	logic [127:0] mem_wdf_data, mem_rd_data;
	logic [15:0] mem_wdf_mask;

	logic [127:0] shadow [4096];
	logic [31:0] lcg_state;
	logic cmd_rd_q [$];
	logic [28:0] cmd_adr_q [$];
	int en_cycles;
	logic [15:0] last_mask;
	logic wdata_held;

	mpmc_top uut (.*);

	mem_model #(.SEED(32'd67556)) u_mem (
		.mem_ui_clk(mem_ui_clk), .mem_ui_rst(mem_ui_rst), .mem_addr(mem_addr),
		.mem_cmd(mem_cmd), .mem_en(mem_en), .mem_wdf_data(mem_wdf_data),
		.mem_wdf_mask(mem_wdf_mask), .mem_wdf_wren(mem_wdf_wren), .mem_wdf_end(mem_wdf_end),
		.mem_rdy(mem_rdy), .mem_wdf_rdy(mem_wdf_rdy), .mem_rd_data(mem_rd_data),
		.mem_rd_data_valid(mem_rd_data_valid)
	);

	initial begin
		mem_ui_clk = 1'b0;
		forever #10 mem_ui_clk = ~mem_ui_clk;
	end

	task automatic fail_now(input string what);
		$display("%s", what);
		$display("** FAIL **");
		$fatal(1);
	endtask

	task automatic check_eq(input string name, input logic [127:0] got,
			input logic [127:0] exp);
		assert (got === exp)
		else fail_now($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
	endtask

	function automatic logic [31:0] rnd();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	// ====================
	// Bus monitor
	// ====================
	always @(posedge mem_ui_clk) begin
		if (mem_ui_rst) begin
			wdata_held <= 1'b0;
		end else begin
			if (mem_en) en_cycles++;
			if (mem_wdf_wren && mem_wdf_rdy) begin
				wdata_held <= 1'b1;
				last_mask <= mem_wdf_mask;
			end
			if (mem_en && mem_rdy) begin
				cmd_rd_q.push_back(mem_cmd == `MPMC_CMD_RD);
				cmd_adr_q.push_back(mem_addr);
				if (mem_cmd == `MPMC_CMD_WR) wdata_held <= 1'b0;
			end
		end
	end

	a_en_hold: assert property (@(posedge mem_ui_clk) disable iff (mem_ui_rst)
		(mem_en && !mem_rdy) |=> (mem_en && $stable(mem_addr) && $stable(mem_cmd)))
		else fail_now($sformatf("[FAIL] mem_en released before accept, mem_addr %h",
			mem_addr));
	a_wdf_hold: assert property (@(posedge mem_ui_clk) disable iff (mem_ui_rst)
		(mem_wdf_wren && !mem_wdf_rdy) |=> (mem_wdf_wren && $stable(mem_wdf_data)))
		else fail_now($sformatf("[FAIL] mem_wdf_wren released early, mem_wdf_data %h",
			mem_wdf_data));
	a_wdf_end: assert property (@(posedge mem_ui_clk) disable iff (mem_ui_rst)
		mem_wdf_end == mem_wdf_wren)
		else fail_now($sformatf("[FAIL] mem_wdf_end %h mem_wdf_wren %h", mem_wdf_end,
			mem_wdf_wren));
	a_data_first: assert property (@(posedge mem_ui_clk) disable iff (mem_ui_rst)
		(mem_en && mem_rdy && mem_cmd == `MPMC_CMD_WR) |-> wdata_held)
		else fail_now($sformatf("[FAIL] write command before data, mem_addr %h", mem_addr));

	// ====================
	// Requester tasks
	// ====================
	task automatic drive_port(input int ch, input logic on, input logic we,
			input logic [31:0] a, input logic [127:0] d, input logic [15:0] s);
		case (ch)
			0: begin
				cyc0 <= on;
				stb0 <= on;
				we0 <= we;
				adr0 <= a;
				dat_w0 <= d;
				sel0 <= s;
			end
			1: begin
				cyc1 <= on;
				stb1 <= on;
				we1 <= we;
				adr1 <= a;
				dat_w1 <= d[63:0];
				sel1 <= s[7:0];
			end
			default: begin
				cyc2 <= on;
				stb2 <= on;
				we2 <= we;
				adr2 <= a;
				dat_w2 <= d[31:0];
				sel2 <= s[3:0];
			end
		endcase
	endtask

	function automatic logic ack_of(input int ch);
		return (ch == 0) ? ack0 : (ch == 1) ? ack1 : ack2;
	endfunction

	function automatic logic [127:0] rdata_of(input int ch);
		return (ch == 0) ? dat_r0 : (ch == 1) ? {64'd0, dat_r1} : {96'd0, dat_r2};
	endfunction

	task automatic handshake(input int ch, input logic we, input logic [31:0] a,
			input logic [127:0] d, input logic [15:0] s, output logic [127:0] r);
		@(posedge mem_ui_clk);
		drive_port(ch, 1'b1, we, a, d, s);
		@(negedge mem_ui_clk);
		while (!ack_of(ch)) @(negedge mem_ui_clk);
		r = rdata_of(ch);
		@(posedge mem_ui_clk);
		drive_port(ch, 1'b0, 1'b0, a, d, s);
	endtask

	task automatic do_read(input int ch, input logic [31:0] a);
		logic [127:0] r;
		logic [127:0] exp;
		int nb;
		int lane;
		nb = 16 >> ch;
		lane = int'(a[3:0]) & ~(nb - 1);
		handshake(ch, 1'b0, a, '0, '0, r);
		exp = shadow[a[15:4]] >> (lane * 8);
		if (nb < 16) exp = exp & ((128'd1 << (nb * 8)) - 128'd1);
		check_eq($sformatf("dat_r%0d", ch), r, exp);
	endtask

	task automatic do_write(input int ch, input logic [31:0] a);
		logic [127:0] d;
		logic [127:0] r;
		logic [15:0] s;
		logic [15:0] exp_mask;
		int nb;
		int lane;
		nb = 16 >> ch;
		lane = int'(a[3:0]) & ~(nb - 1);
		d = {rnd(), rnd(), rnd(), rnd()};
		s = 16'(rnd() & ((1 << nb) - 1)) | 16'd1;
		handshake(ch, 1'b1, a, d, s, r);
		// Selected bytes land at the lane and open their mask bits
		exp_mask = '1;
		for (int b = 0; b < nb; b++) begin
			if (s[b]) begin
				shadow[a[15:4]][(lane + b) * 8 +: 8] = d[b*8 +: 8];
				exp_mask[lane + b] = 1'b0;
			end
		end
		check_eq("mem_wdf_mask", {112'd0, last_mask}, {112'd0, exp_mask});
		check_eq("mem strip", u_mem.store[a[15:4]], shadow[a[15:4]]);
	endtask

	task automatic clear_log();
		cmd_rd_q.delete();
		cmd_adr_q.delete();
		en_cycles = 0;
	endtask

	// Read burst is one command per strip stepping up from the line base
	task automatic check_burst(input int ch, input logic [28:0] base);
		int n;
		n = 4 >> ch;
		check_eq("read command count", 128'(cmd_rd_q.size()), 128'(n));
		for (int i = 0; i < n; i++) begin
			check_eq("mem_cmd read", {127'd0, cmd_rd_q[i]}, 128'd1);
			check_eq("mem_addr", {99'd0, cmd_adr_q[i]}, {99'd0, base + 29'(16 * i)});
		end
	endtask

	initial begin
		repeat (NTESTS * 2000) @(posedge mem_ui_clk);
		$display("Timeout, the run did not finish in time");
		$display("** FAIL **");
		$fatal(1);
	end

	// ====================
	// Test sequence
	// ====================
	initial begin
		logic [31:0] rand_adr;
		lcg_state = 32'd67556;
		en_cycles = 0;
		mem_ui_rst <= 1'b1;
		for (int ch = 0; ch < 3; ch++) drive_port(ch, 1'b0, 1'b0, '0, '0, '0);
		repeat (10) @(posedge mem_ui_clk);
		mem_ui_rst <= 1'b0;
		for (int i = 0; i < 4096; i++) shadow[i] = u_mem.store[i];

		// Miss and burst shape followed by a hit in the same line
		clear_log();
		do_read(0, 32'h1000);
		check_burst(0, 29'h1000);
		clear_log();
		do_read(0, 32'h1030);
		check_eq("hit mem_en cycles", 128'(en_cycles), 0);
		clear_log();
		do_read(1, 32'h2028);
		check_burst(1, 29'h2020);
		clear_log();
		do_read(1, 32'h2038);
		check_eq("hit mem_en cycles", 128'(en_cycles), 0);
		clear_log();
		do_read(2, 32'h3004);
		check_burst(2, 29'h3000);
		clear_log();
		do_read(2, 32'h3008);
		check_eq("hit mem_en cycles", 128'(en_cycles), 0);

		// Partial writes on each channel
		do_write(0, 32'h4010);
		do_write(1, 32'h4028);
		do_write(2, 32'h4038);

		// Write by another channel invalidates the cached line
		do_read(0, 32'h5000);
		do_write(2, 32'h5024);
		clear_log();
		do_read(0, 32'h5020);
		check_burst(0, 29'h5000);

		// Write beats a read miss and the lower channel wins among misses
		clear_log();
		fork
			do_read(2, 32'h6000);
			do_write(1, 32'h6100);
		join
		check_eq("first mem_cmd", {127'd0, cmd_rd_q[0]}, 128'd0);
		check_eq("first mem_addr", {99'd0, cmd_adr_q[0]}, 128'h6100);
		clear_log();
		fork
			do_read(0, 32'h7000);
			do_read(2, 32'h7100);
		join
		check_eq("first mem_addr", {99'd0, cmd_adr_q[0]}, 128'h7000);

		// Random writes read back on every channel under ready stalls
		for (int k = 0; k < 4; k++) begin
			for (int ch = 0; ch < 3; ch++) begin
				rand_adr = {16'd0, 16'(rnd())};
				do_write(ch, rand_adr);
				do_read(ch, rand_adr);
			end
		end

		repeat (5) @(posedge mem_ui_clk);
		$display("** PASS **");
		$finish;
	end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator and run, pass only if the pass line shows up
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module mpmc_tb

./obj_dir/Vmpmc_tb | tee /dev/stderr | grep -qF "** PASS **"

echo "Simulation passed"

// ==== source/chan_port.sv ====
`include "mpmc_params.svh"

module chan_port import mpmc_pkg::*; #(
	parameter type data_t = logic [127:0],
	parameter int LINE_STRIPS = 4
) (
	input  logic mem_ui_clk,
	input  logic mem_ui_rst,
	// Requester side
	input  logic cyc,
	input  logic stb,
	input  logic we,
	input  logic [$bits(data_t)/8-1:0] sel,
	input  logic [31:0] adr,
	input  data_t dat_w,
	output logic ack,
	output data_t dat_r,
	// Request towards the sequencer
	output logic req_rd_miss,
	output logic req_wr,
	output mem_addr_t req_adr,
	output mask_t req_mask,
	output strip_t req_data,
	output logic ack_int,
	// Fill, completion and invalidation from the sequencer
	input  logic fill_valid,
	input  strip_cnt_t fill_strip,
	input  logic fill_last,
	input  strip_t fill_data,
	input  logic wr_done,
	input  logic inval_valid,
	input  mem_addr_t inval_adr
);

	localparam int DATA_W = $bits(data_t);
	localparam int SEL_W = DATA_W / 8;
	localparam int LANES = `MPMC_STRIP_W / DATA_W;
	localparam int IDX_W = (LINE_STRIPS > 1) ? $clog2(LINE_STRIPS) : 1;
	localparam int LINE_LSB = 4 + $clog2(LINE_STRIPS);
	// Address bits below the strip that pick the word lane
	localparam logic [3:0] LANE_MASK = 4'(16 - SEL_W);
	localparam mem_addr_t LINE_ALIGN = ~mem_addr_t'((1 << LINE_LSB) - 1);
	localparam mem_addr_t STRIP_ALIGN = ~mem_addr_t'(15);

	strip_t line_mem [LINE_STRIPS];
	logic tag_valid;
	logic [`MPMC_AMSB:LINE_LSB] tag_line;
	logic cs;
	logic hit;
	logic [IDX_W-1:0] rd_idx;
	logic [3:0] lane_byte;

	// ====================
	// Select and hit
	// ====================

	assign cs = cyc & stb & (adr[`MPMC_REGION_MSB:`MPMC_AMSB+1] == '0);

	// Line granular tag compare
	assign hit = cs & ~we & tag_valid & (adr[`MPMC_AMSB:LINE_LSB] == tag_line);

	// Requests stay quiet once acknowledged, until the select drops
	assign req_rd_miss = cs & ~we & ~hit & ~ack_int;
	assign req_wr = cs & we & ~ack_int;

	// Ack terminates with the live select
	assign ack = ack_int & cs;

	always_ff @(posedge mem_ui_clk) begin
		if (mem_ui_rst) begin
			ack_int <= 1'b0;
		end else if (!cs) begin
			ack_int <= 1'b0;
		end else if (hit || wr_done) begin
			ack_int <= 1'b1;
		end
	end

	// ====================
	// Line cache and tag
	// ====================

	// Tag is set by the final strip of a burst, cleared by a write to the line
	always_ff @(posedge mem_ui_clk) begin
		if (mem_ui_rst) begin
			tag_valid <= 1'b0;
		end else if (fill_valid && fill_last) begin
			tag_valid <= 1'b1;
		end else if (inval_valid && inval_adr[`MPMC_AMSB:LINE_LSB] == tag_line) begin
			tag_valid <= 1'b0;
		end
	end

	always_ff @(posedge mem_ui_clk) begin
		if (fill_valid && fill_last) begin
			tag_line <= adr[`MPMC_AMSB:LINE_LSB];
		end
	end

	always_ff @(posedge mem_ui_clk) begin
		if (fill_valid) begin
			line_mem[fill_strip[IDX_W-1:0]] <= fill_data;
		end
	end

	// ====================
	// Read lane select
	// ====================

	// Single strip lines have no strip index bits in the address
	assign rd_idx = (LINE_STRIPS > 1) ? adr[4 +: IDX_W] : '0;
	assign lane_byte = adr[3:0] & LANE_MASK;
	assign dat_r = data_t'(line_mem[rd_idx] >> {lane_byte, 3'b000});

	// ====================
	// Write steering
	// ====================

	// Reads fetch the whole line, writes touch a single strip
	assign req_adr = adr[`MPMC_AMSB:0] & (we ? STRIP_ALIGN : LINE_ALIGN);

	// Word copied into every lane, mask opens only the selected bytes
	assign req_data = {LANES{dat_w}};
	assign req_mask = ~(mask_t'(sel) << lane_byte);

endmodule

// ==== source/mem_sequencer.sv ====
`include "mpmc_params.svh"

module mem_sequencer import mpmc_pkg::*; (
	input  logic mem_ui_clk,
	input  logic mem_ui_rst,
	// Channel ports
	input  logic [`MPMC_NCH-1:0] req_rd_miss,
	input  logic [`MPMC_NCH-1:0] req_wr,
	input  mem_addr_t [`MPMC_NCH-1:0] req_adr,
	input  mask_t [`MPMC_NCH-1:0] req_mask,
	input  strip_t [`MPMC_NCH-1:0] req_data,
	input  logic [`MPMC_NCH-1:0] ack_int,
	output logic [`MPMC_NCH-1:0] fill_valid,
	output strip_cnt_t fill_strip,
	output logic fill_last,
	output logic [`MPMC_NCH-1:0] wr_done,
	output logic inval_valid,
	output mem_addr_t inval_adr,
	// DDR user interface
	output mem_addr_t mem_addr,
	output logic [2:0] mem_cmd,
	output logic mem_en,
	output strip_t mem_wdf_data,
	output mask_t mem_wdf_mask,
	output logic mem_wdf_wren,
	output logic mem_wdf_end,
	input  logic mem_rdy,
	input  logic mem_wdf_rdy,
	input  logic mem_rd_data_valid
);

	localparam int NCH = `MPMC_NCH;

	seq_state_t state;
	chan_id_t nch;
	logic nch_wr;
	mem_addr_t nch_adr;
	mask_t nch_mask;
	strip_t nch_data;
	logic [NCH-1:0] grant_oh;
	logic do_wr;
	strip_cnt_t last_strip;
	strip_cnt_t cmd_cnt;
	strip_cnt_t ret_cnt;
	logic gack;
	logic ack_q;
	logic ack_fall;
	logic rd_beat;

	// Index of the final strip in a channel's line
	function automatic strip_cnt_t line_last(chan_id_t ch);
		case (ch)
			2'd0: return strip_cnt_t'(`MPMC_CH0_STRIPS - 1);
			2'd1: return strip_cnt_t'(`MPMC_CH1_STRIPS - 1);
			2'd2: return strip_cnt_t'(`MPMC_CH2_STRIPS - 1);
			default: return '0;
		endcase
	endfunction

	// ====================
	// Grant selection
	// ====================

	// Writes beat read misses, lower channel wins inside each class
	always_comb begin
		nch = CH_NONE;
		nch_wr = 1'b0;
		for (int i = NCH - 1; i >= 0; i--) begin
			if (req_rd_miss[i]) begin
				nch = chan_id_t'(i);
			end
		end
		for (int i = NCH - 1; i >= 0; i--) begin
			if (req_wr[i]) begin
				nch = chan_id_t'(i);
				nch_wr = 1'b1;
			end
		end
	end

	always_comb begin
		nch_adr = '0;
		nch_mask = '1;
		nch_data = '0;
		for (int i = 0; i < NCH; i++) begin
			if (nch == chan_id_t'(i)) begin
				nch_adr = req_adr[i];
				nch_mask = req_mask[i];
				nch_data = req_data[i];
			end
		end
	end

	// Granted write knocks the line out of every port's cache
	assign inval_valid = (state == IDLE) && nch_wr;
	assign inval_adr = nch_adr;

	always_ff @(posedge mem_ui_clk) begin
		if (mem_ui_rst) begin
			grant_oh <= '0;
			do_wr <= 1'b0;
			last_strip <= '0;
		end else if (state == IDLE && nch != CH_NONE) begin
			grant_oh <= NCH'(1) << nch;
			do_wr <= nch_wr;
			last_strip <= nch_wr ? '0 : line_last(nch);
		end
	end

	// Command address steps one strip per accepted read
	always_ff @(posedge mem_ui_clk) begin
		if (state == IDLE) begin
			mem_addr <= nch_adr;
			mem_wdf_data <= nch_data;
			mem_wdf_mask <= nch_mask;
		end else if (state == SET_CMD_RD && mem_rdy) begin
			mem_addr <= mem_addr + mem_addr_t'(16);
		end
	end

	// ====================
	// Strip counters
	// ====================

	assign rd_beat = (state == SET_CMD_RD || state == WAIT_RD) && mem_rd_data_valid;

	always_ff @(posedge mem_ui_clk) begin
		if (mem_ui_rst || state == IDLE) begin
			cmd_cnt <= '0;
			ret_cnt <= '0;
		end else begin
			if (state == SET_CMD_RD && mem_rdy) begin
				cmd_cnt <= cmd_cnt + strip_cnt_t'(1);
			end
			if (rd_beat) begin
				ret_cnt <= ret_cnt + strip_cnt_t'(1);
			end
		end
	end

	// Returned strips go to the granted port only
	assign fill_valid = grant_oh & {NCH{rd_beat}};
	assign fill_strip = ret_cnt;
	assign fill_last = rd_beat && (ret_cnt == last_strip);

	assign wr_done = grant_oh & {NCH{state == SET_CMD_WR && mem_rdy}};

	// Falling ack of the granted port closes the transaction
	assign gack = |(ack_int & grant_oh);
	assign ack_fall = ack_q & ~gack;

	always_ff @(posedge mem_ui_clk) begin
		if (mem_ui_rst) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= gack;
		end
	end

	// ====================
	// State machine
	// ====================

	always_ff @(posedge mem_ui_clk) begin
		if (mem_ui_rst) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE: begin
					if (nch != CH_NONE) begin
						state <= PRESET;
					end
				end
				PRESET: begin
					state <= do_wr ? SEND_DATA : SET_CMD_RD;
				end
				SEND_DATA: begin
					if (mem_wdf_rdy) begin
						state <= SET_CMD_WR;
					end
				end
				SET_CMD_WR: begin
					if (mem_rdy) begin
						state <= WAIT_NACK;
					end
				end
				SET_CMD_RD: begin
					if (mem_rdy && cmd_cnt == last_strip) begin
						state <= WAIT_RD;
					end
				end
				WAIT_RD: begin
					if (fill_last) begin
						state <= WAIT_NACK;
					end
				end
				WAIT_NACK: begin
					if (ack_fall) begin
						state <= IDLE;
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	// Data goes out one state ahead of its write command
	assign mem_wdf_wren = (state == SEND_DATA);
	assign mem_wdf_end = (state == SEND_DATA);
	assign mem_en = (state == SET_CMD_RD) || (state == SET_CMD_WR);
	assign mem_cmd = (state == SET_CMD_RD) ? `MPMC_CMD_RD : `MPMC_CMD_WR;

endmodule

// ==== source/mpmc_params.svh ====
`ifndef MPMC_PARAMS_SVH
`define MPMC_PARAMS_SVH

// Memory address and data path geometry
`define MPMC_AMSB 28
`define MPMC_STRIP_W 128
`define MPMC_MASK_W 16

// Requester count
`define MPMC_NCH 3

// DDR user interface command codes
`define MPMC_CMD_RD 3'd1
`define MPMC_CMD_WR 3'd0

// Cached line length per channel, in 16-byte strips
`define MPMC_CH0_STRIPS 4
`define MPMC_CH1_STRIPS 2
`define MPMC_CH2_STRIPS 1

// Bits above the memory address must be zero to select the controller
`define MPMC_REGION_MSB 31

`endif

// ==== source/mpmc_pkg.sv ====
`include "mpmc_params.svh"

package mpmc_pkg;

	// Channel number, value 3 marks no channel
	typedef logic [1:0] chan_id_t;
	localparam chan_id_t CH_NONE = 2'd3;

	// One memory strip and its byte mask
	typedef logic [`MPMC_STRIP_W-1:0] strip_t;
	// A set mask bit keeps the memory byte
	typedef logic [`MPMC_MASK_W-1:0] mask_t;

	// Byte address as seen by the memory controller
	typedef logic [`MPMC_AMSB:0] mem_addr_t;

	// Strip index within a line
	typedef logic [1:0] strip_cnt_t;

	// ====================
	// Sequencer states
	// ====================
	typedef enum logic [2:0] {
		IDLE       = 3'd0,
		PRESET     = 3'd1,
		SEND_DATA  = 3'd2,
		SET_CMD_WR = 3'd3,
		SET_CMD_RD = 3'd4,
		WAIT_RD    = 3'd5,
		WAIT_NACK  = 3'd6
	} seq_state_t;

endpackage

// ==== source/mpmc_top.sv ====
`include "mpmc_params.svh"

module mpmc_top import mpmc_pkg::*; (
	input  logic mem_ui_clk,
	input  logic mem_ui_rst,
	// Channel 0, display fetch
	input  logic cyc0,
	input  logic stb0,
	input  logic we0,
	input  logic [15:0] sel0,
	input  logic [31:0] adr0,
	input  logic [127:0] dat_w0,
	output logic ack0,
	output logic [127:0] dat_r0,
	// Channel 1, CPU
	input  logic cyc1,
	input  logic stb1,
	input  logic we1,
	input  logic [7:0] sel1,
	input  logic [31:0] adr1,
	input  logic [63:0] dat_w1,
	output logic ack1,
	output logic [63:0] dat_r1,
	// Channel 2, narrow peripherals
	input  logic cyc2,
	input  logic stb2,
	input  logic we2,
	input  logic [3:0] sel2,
	input  logic [31:0] adr2,
	input  logic [31:0] dat_w2,
	output logic ack2,
	output logic [31:0] dat_r2,
	// DDR user interface
	output mem_addr_t mem_addr,
	output logic [2:0] mem_cmd,
	output logic mem_en,
	output strip_t mem_wdf_data,
	output mask_t mem_wdf_mask,
	output logic mem_wdf_wren,
	output logic mem_wdf_end,
	input  logic mem_rdy,
	input  logic mem_wdf_rdy,
	input  strip_t mem_rd_data,
	input  logic mem_rd_data_valid
);

	logic [`MPMC_NCH-1:0] req_rd_miss;
	logic [`MPMC_NCH-1:0] req_wr;
	mem_addr_t [`MPMC_NCH-1:0] req_adr;
	mask_t [`MPMC_NCH-1:0] req_mask;
	strip_t [`MPMC_NCH-1:0] req_data;
	logic [`MPMC_NCH-1:0] ack_int;
	logic [`MPMC_NCH-1:0] fill_valid;
	strip_cnt_t fill_strip;
	logic fill_last;
	logic [`MPMC_NCH-1:0] wr_done;
	logic inval_valid;
	mem_addr_t inval_adr;

	// ====================
	// Requester ports
	// ====================

	chan_port #(
		.data_t(logic [127:0]),
		.LINE_STRIPS(`MPMC_CH0_STRIPS)
	) u_port0 (
		.mem_ui_clk(mem_ui_clk), .mem_ui_rst(mem_ui_rst),
		.cyc(cyc0), .stb(stb0), .we(we0), .sel(sel0), .adr(adr0), .dat_w(dat_w0),
		.ack(ack0), .dat_r(dat_r0),
		.req_rd_miss(req_rd_miss[0]), .req_wr(req_wr[0]), .req_adr(req_adr[0]),
		.req_mask(req_mask[0]), .req_data(req_data[0]), .ack_int(ack_int[0]),
		.fill_valid(fill_valid[0]), .fill_strip(fill_strip), .fill_last(fill_last),
		.fill_data(mem_rd_data), .wr_done(wr_done[0]),
		.inval_valid(inval_valid), .inval_adr(inval_adr)
	);

	chan_port #(
		.data_t(logic [63:0]),
		.LINE_STRIPS(`MPMC_CH1_STRIPS)
	) u_port1 (
		.mem_ui_clk(mem_ui_clk), .mem_ui_rst(mem_ui_rst),
		.cyc(cyc1), .stb(stb1), .we(we1), .sel(sel1), .adr(adr1), .dat_w(dat_w1),
		.ack(ack1), .dat_r(dat_r1),
		.req_rd_miss(req_rd_miss[1]), .req_wr(req_wr[1]), .req_adr(req_adr[1]),
		.req_mask(req_mask[1]), .req_data(req_data[1]), .ack_int(ack_int[1]),
		.fill_valid(fill_valid[1]), .fill_strip(fill_strip), .fill_last(fill_last),
		.fill_data(mem_rd_data), .wr_done(wr_done[1]),
		.inval_valid(inval_valid), .inval_adr(inval_adr)
	);

	chan_port #(
		.data_t(logic [31:0]),
		.LINE_STRIPS(`MPMC_CH2_STRIPS)
	) u_port2 (
		.mem_ui_clk(mem_ui_clk), .mem_ui_rst(mem_ui_rst),
		.cyc(cyc2), .stb(stb2), .we(we2), .sel(sel2), .adr(adr2), .dat_w(dat_w2),
		.ack(ack2), .dat_r(dat_r2),
		.req_rd_miss(req_rd_miss[2]), .req_wr(req_wr[2]), .req_adr(req_adr[2]),
		.req_mask(req_mask[2]), .req_data(req_data[2]), .ack_int(ack_int[2]),
		.fill_valid(fill_valid[2]), .fill_strip(fill_strip), .fill_last(fill_last),
		.fill_data(mem_rd_data), .wr_done(wr_done[2]),
		.inval_valid(inval_valid), .inval_adr(inval_adr)
	);

	// ====================
	// Memory sequencer
	// ====================

	mem_sequencer u_seq (
		.mem_ui_clk(mem_ui_clk), .mem_ui_rst(mem_ui_rst),
		.req_rd_miss(req_rd_miss), .req_wr(req_wr), .req_adr(req_adr),
		.req_mask(req_mask), .req_data(req_data), .ack_int(ack_int),
		.fill_valid(fill_valid), .fill_strip(fill_strip), .fill_last(fill_last),
		.wr_done(wr_done), .inval_valid(inval_valid), .inval_adr(inval_adr),
		.mem_addr(mem_addr), .mem_cmd(mem_cmd), .mem_en(mem_en),
		.mem_wdf_data(mem_wdf_data), .mem_wdf_mask(mem_wdf_mask),
		.mem_wdf_wren(mem_wdf_wren), .mem_wdf_end(mem_wdf_end),
		.mem_rdy(mem_rdy), .mem_wdf_rdy(mem_wdf_rdy),
		.mem_rd_data_valid(mem_rd_data_valid)
	);

endmodule
